/* src/read_ctrl_pkg.sv */
////////////////////
// shared sizes, opcodes and structs for the read engine control block
// every module imports this package; the testbench uses the same types
////////////////////

`default_nettype none

package read_ctrl_pkg;

	// element and line geometry
	localparam int ELEM_BYTES      = 4;
	localparam int CACHELINE_BYTES = 128;
	localparam int CACHELINE_ELEMS = 32;
	localparam int PAGE_BYTES      = 4096;
	localparam int PAGE_ELEMS      = 1024;
	localparam int MAX_BATCH_READS = 4;

	// field widths
	localparam int ADDR_W  = 64;
	localparam int SIZE_W  = 32;
	localparam int CHUNK_W = 11;

	typedef enum logic [1:0] {
		READ_CL_S  = 2'd0,
		READ_CL_NA = 2'd1,
		READ_PNA   = 2'd2,
		TOUCH_I    = 2'd3
	} cmd_op_e;

	typedef enum logic [3:0] {
		SEQ_IDLE     = 4'd0,
		SEQ_LOAD     = 4'd1,
		SEQ_PF_BURST = 4'd2,
		SEQ_PF_WAIT  = 4'd3,
		SEQ_RD_BURST = 4'd4,
		SEQ_RD_WAIT  = 4'd5,
		SEQ_DONE     = 4'd6
	} seq_state_e;

	// job descriptor with its size counted in elements
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] base_addr;
		logic [SIZE_W-1:0] size;
		logic              shared;
	} job_t;

	typedef struct packed {
		logic               valid;
		logic [ADDR_W-1:0]  address;
		logic [CHUNK_W-1:0] real_size;
	} chunk_t;

	typedef struct packed {
		chunk_t  chunk;
		cmd_op_e op;
	} cmd_t;

	typedef struct packed {
		logic               valid;
		logic [CHUNK_W-1:0] real_size;
	} resp_t;

endpackage

`default_nettype wire

/* src/chunk_issuer.sv */
////////////////////
// splits a latched job into fixed-size chunks with stepping addresses
// load latches the job, start opens a burst of up to BURST_MAX chunks
// burst_end pulses one cycle after the last chunk of the burst
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chunk_issuer #(
	parameter int CHUNK_ELEMS = read_ctrl_pkg::CACHELINE_ELEMS,
	parameter int STEP_BYTES  = read_ctrl_pkg::CACHELINE_BYTES,
	parameter int BURST_MAX   = read_ctrl_pkg::MAX_BATCH_READS,
	parameter bit ALIGN_PAGE  = 1'b0
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  load,
	input  read_ctrl_pkg::job_t   job,
	input  logic                  start,
	input  logic                  stall,
	output read_ctrl_pkg::chunk_t chunk,
	output logic                  burst_end,
	output logic [2:0]            burst_count,
	output logic                  drained
);

	import read_ctrl_pkg::*;

	localparam logic [CHUNK_W-1:0] CHUNK_SIZE = CHUNK_W'(CHUNK_ELEMS);
	localparam logic [ADDR_W-1:0]  STEP       = ADDR_W'(STEP_BYTES);
	localparam logic [ADDR_W-1:0]  PAGE_MASK  = ~(ADDR_W'(PAGE_BYTES) - 1'b1);
	localparam logic [2:0]         BURST_LAST = 3'(BURST_MAX - 1);

	logic [ADDR_W-1:0]  base;
	logic [ADDR_W-1:0]  offset;
	logic [SIZE_W-1:0]  remaining;
	logic               burst_open;
	logic [2:0]         issued;
	logic               last_q;
	logic               issue;
	logic               closing;
	logic [CHUNK_W-1:0] take;

	// the next chunk is short only at the tail of the job
	assign take = (remaining < SIZE_W'(CHUNK_ELEMS)) ? remaining[CHUNK_W-1:0] : CHUNK_SIZE;

	assign issue = burst_open && !stall && (remaining != '0);

	// last slot of the burst, or this chunk empties the job
	assign closing = (issued == BURST_LAST) || (remaining == SIZE_W'(take));

	assign drained     = (remaining == '0);
	assign burst_count = issued;

	////////////////////
	// chunk generation
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			base       <= '0;
			offset     <= '0;
			remaining  <= '0;
			burst_open <= 1'b0;
			issued     <= '0;
			last_q     <= 1'b0;
			burst_end  <= 1'b0;
			chunk      <= '0;
		end else begin
			chunk.valid <= 1'b0;
			last_q      <= 1'b0;
			burst_end   <= last_q;

			if (load) begin
				base      <= ALIGN_PAGE ? (job.base_addr & PAGE_MASK) : job.base_addr;
				remaining <= job.size;
				offset    <= '0;
			end

			if (start) begin
				burst_open <= 1'b1;
				issued     <= '0;
			end else if (issue) begin
				chunk.valid     <= 1'b1;
				chunk.address   <= base + offset;
				chunk.real_size <= take;
				offset          <= offset + STEP;
				remaining       <= remaining - SIZE_W'(take);
				issued          <= issued + 3'd1;
				if (closing) begin
					burst_open <= 1'b0;
					last_q     <= 1'b1;
				end
			end else if (burst_open && drained) begin
				// opened with nothing left, close it empty
				burst_open <= 1'b0;
				last_q     <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/read_sequencer.sv */
////////////////////
// job FSM of the read engine
// alternates page-touch and read bursts, waits for every response of a
// burst, formats chunks into commands and totals completed elements
////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_sequencer (
	input  logic                                clock,
	input  logic                                rstn,
	input  read_ctrl_pkg::job_t                 job,
	input  logic                                prefetch_en,
	input  read_ctrl_pkg::chunk_t               read_chunk,
	input  logic                                read_burst_end,
	input  logic [2:0]                          read_burst_count,
	input  logic                                read_drained,
	input  read_ctrl_pkg::chunk_t               page_chunk,
	input  logic                                page_burst_end,
	input  logic [2:0]                          page_burst_count,
	input  logic                                page_drained,
	input  read_ctrl_pkg::resp_t                read_resp,
	input  read_ctrl_pkg::resp_t                prefetch_resp,
	output logic                                read_load,
	output logic                                page_load,
	output logic                                read_start,
	output logic                                page_start,
	output read_ctrl_pkg::cmd_t                 read_cmd,
	output read_ctrl_pkg::cmd_t                 prefetch_cmd,
	output logic                                done,
	output logic [read_ctrl_pkg::SIZE_W-1:0]    done_elems
);

	import read_ctrl_pkg::*;

	seq_state_e state;
	logic       job_take;
	logic       shared_q;
	logic       pf_on;
	logic       resp_hit;
	logic [2:0] resp_cnt;
	cmd_op_e    read_op;

	// both issuers take the job on the cycle it is accepted
	assign job_take  = (state == SEQ_IDLE) && job.valid;
	assign read_load = job_take;
	assign page_load = job_take;

	assign done = (state == SEQ_DONE);

	// only responses of the running phase count
	always_comb begin
		case (state)
			SEQ_PF_BURST, SEQ_PF_WAIT: resp_hit = prefetch_resp.valid;
			SEQ_RD_BURST, SEQ_RD_WAIT: resp_hit = read_resp.valid;
			default:                   resp_hit = 1'b0;
		endcase
	end

	////////////////////
	// job FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= SEQ_IDLE;
			read_start <= 1'b0;
			page_start <= 1'b0;
			shared_q   <= 1'b0;
			pf_on      <= 1'b0;
			resp_cnt   <= '0;
		end else begin
			read_start <= 1'b0;
			page_start <= 1'b0;
			resp_cnt   <= resp_cnt + {2'b00, resp_hit};

			case (state)
				SEQ_IDLE: begin
					if (job.valid) begin
						shared_q <= job.shared;
						pf_on    <= prefetch_en;
						state    <= SEQ_LOAD;
					end
				end
				// issuers hold the job from this cycle on
				SEQ_LOAD: begin
					if (pf_on) begin
						page_start <= 1'b1;
						state      <= SEQ_PF_BURST;
					end else begin
						read_start <= 1'b1;
						state      <= SEQ_RD_BURST;
					end
				end
				SEQ_PF_BURST: begin
					if (page_burst_end)
						state <= SEQ_PF_WAIT;
				end
				SEQ_PF_WAIT: begin
					if (resp_cnt == page_burst_count) begin
						resp_cnt   <= '0;
						read_start <= 1'b1;
						state      <= SEQ_RD_BURST;
					end
				end
				SEQ_RD_BURST: begin
					if (read_burst_end)
						state <= SEQ_RD_WAIT;
				end
				SEQ_RD_WAIT: begin
					if (resp_cnt == read_burst_count) begin
						resp_cnt <= '0;
						if (pf_on && !page_drained) begin
							page_start <= 1'b1;
							state      <= SEQ_PF_BURST;
						end else if (!read_drained) begin
							read_start <= 1'b1;
							state      <= SEQ_RD_BURST;
						end else begin
							state <= SEQ_DONE;
						end
					end
				end
				// done holds until reset
				default: state <= state;
			endcase
		end
	end

	////////////////////
	// command formatting
	////////////////////

	// the issuer has already drained when it shows its last chunk
	assign read_op = shared_q ? READ_CL_S : (read_drained ? READ_PNA : READ_CL_NA);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd     <= '0;
			prefetch_cmd <= '0;
		end else begin
			read_cmd     <= '0;
			prefetch_cmd <= '0;
			if (read_chunk.valid) begin
				read_cmd.chunk <= read_chunk;
				read_cmd.op    <= read_op;
			end
			if (page_chunk.valid) begin
				prefetch_cmd.chunk <= page_chunk;
				prefetch_cmd.op    <= TOUCH_I;
			end
		end
	end

	// completed elements from read responses
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			done_elems <= '0;
		else if (read_resp.valid)
			done_elems <= done_elems + SIZE_W'(read_resp.real_size);
	end

endmodule

`default_nettype wire

/* src/read_ctrl_top.sv */
////////////////////
// read engine control top level
// a cacheline issuer and a page issuer under one sequencer
////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_ctrl_top (
	input  logic                             clock,
	input  logic                             rstn,
	input  read_ctrl_pkg::job_t              job,
	input  logic                             prefetch_en,
	input  logic                             read_stall,
	input  logic                             prefetch_stall,
	input  read_ctrl_pkg::resp_t             read_resp,
	input  read_ctrl_pkg::resp_t             prefetch_resp,
	output read_ctrl_pkg::cmd_t              read_cmd,
	output read_ctrl_pkg::cmd_t              prefetch_cmd,
	output logic                             done,
	output logic [read_ctrl_pkg::SIZE_W-1:0] done_elems
);

	import read_ctrl_pkg::*;

	logic       read_load;
	logic       page_load;
	logic       read_start;
	logic       page_start;
	chunk_t     read_chunk;
	chunk_t     page_chunk;
	logic       read_burst_end;
	logic       page_burst_end;
	logic [2:0] read_burst_count;
	logic [2:0] page_burst_count;
	logic       read_drained;
	logic       page_drained;

	////////////////////
	// issuers
	////////////////////

	// one cacheline per read, batches of four
	chunk_issuer #(
		.CHUNK_ELEMS (CACHELINE_ELEMS),
		.STEP_BYTES  (CACHELINE_BYTES),
		.BURST_MAX   (MAX_BATCH_READS),
		.ALIGN_PAGE  (1'b0)
	) read_issuer (
		.clock       (clock),
		.rstn        (rstn),
		.load        (read_load),
		.job         (job),
		.start       (read_start),
		.stall       (read_stall),
		.chunk       (read_chunk),
		.burst_end   (read_burst_end),
		.burst_count (read_burst_count),
		.drained     (read_drained)
	);

	// one page touch per burst, from the page-aligned base
	chunk_issuer #(
		.CHUNK_ELEMS (PAGE_ELEMS),
		.STEP_BYTES  (PAGE_BYTES),
		.BURST_MAX   (1),
		.ALIGN_PAGE  (1'b1)
	) page_issuer (
		.clock       (clock),
		.rstn        (rstn),
		.load        (page_load),
		.job         (job),
		.start       (page_start),
		.stall       (prefetch_stall),
		.chunk       (page_chunk),
		.burst_end   (page_burst_end),
		.burst_count (page_burst_count),
		.drained     (page_drained)
	);

	read_sequencer sequencer (
		.clock            (clock),
		.rstn             (rstn),
		.job              (job),
		.prefetch_en      (prefetch_en),
		.read_chunk       (read_chunk),
		.read_burst_end   (read_burst_end),
		.read_burst_count (read_burst_count),
		.read_drained     (read_drained),
		.page_chunk       (page_chunk),
		.page_burst_end   (page_burst_end),
		.page_burst_count (page_burst_count),
		.page_drained     (page_drained),
		.read_resp        (read_resp),
		.prefetch_resp    (prefetch_resp),
		.read_load        (read_load),
		.page_load        (page_load),
		.read_start       (read_start),
		.page_start       (page_start),
		.read_cmd         (read_cmd),
		.prefetch_cmd     (prefetch_cmd),
		.done             (done),
		.done_elems       (done_elems)
	);

endmodule

`default_nettype wire

/* sim/cmd_responder.sv */
////////////////////
// memory-side model for one command port
// answers every command once, in order, after a random delay
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_responder #(
	parameter int          DELAY_MAX = 8,
	parameter logic [31:0] SEED      = 32'hd085b92a
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  read_ctrl_pkg::cmd_t  cmd,
	output read_ctrl_pkg::resp_t resp
);

	import read_ctrl_pkg::*;

	integer             seed;
	int                 delay_q[$];
	logic [CHUNK_W-1:0] size_q[$];
	logic [CHUNK_W-1:0] head_size;

	initial begin
		seed = SEED;
		resp = '0;
	end

	// at most one answer per cycle on the falling edge
	always @(negedge clock) begin
		resp = '0;
		if (!rstn) begin
			delay_q.delete();
			size_q.delete();
		end else begin
			if (delay_q.size() > 0) begin
				if (delay_q[0] == 0) begin
					head_size = size_q.pop_front();
					void'(delay_q.pop_front());
					resp.valid     = 1'b1;
					resp.real_size = head_size;
				end else begin
					delay_q[0] = delay_q[0] - 1;
				end
			end
			if (cmd.chunk.valid) begin
				delay_q.push_back(int'($unsigned($random(seed)) % DELAY_MAX));
				size_q.push_back(cmd.chunk.real_size);
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_read_ctrl.sv */
////////////////////
// testbench for the read engine control block
// runs a list of jobs, each after a fresh reset, under random stalls
// and random response delays; concurrent assertions do the checking
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_read_ctrl;

	import read_ctrl_pkg::*;

	localparam int          NUM_JOBS = 6;
	localparam logic [31:0] SEED     = 32'hd085b92a;

	logic              clock = 1'b0;
	logic              rstn;
	job_t              job;
	logic              prefetch_en;
	logic              read_stall;
	logic              prefetch_stall;
	resp_t             read_resp;
	resp_t             prefetch_resp;
	cmd_t              read_cmd;
	cmd_t              prefetch_cmd;
	logic              done;
	logic [SIZE_W-1:0] done_elems;

	integer            seed;
	int                cycles;
	int                limit;
	logic [ADDR_W-1:0] job_base [NUM_JOBS];
	int                job_size [NUM_JOBS];
	bit                job_shared [NUM_JOBS];
	bit                job_pf [NUM_JOBS];

	// job under test
	logic [ADDR_W-1:0] cur_base;
	int                cur_size;
	bit                cur_shared;
	bit                cur_pf;

	// scoreboard counts taken from the ports
	int   rd_issued;
	int   rd_answered;
	int   rd_sum;
	int   pf_issued;
	int   pf_answered;
	logic rstall_q1;
	logic rstall_q2;
	logic pstall_q1;
	logic pstall_q2;

	logic [ADDR_W-1:0] pf_base;
	logic [ADDR_W-1:0] exp_rd_addr;
	logic [ADDR_W-1:0] exp_pf_addr;
	int                n_reads;
	int                n_pages;
	int                rd_left;
	int                pf_left;
	int                exp_rd_size;
	int                exp_pf_size;
	int                rd_page;
	cmd_op_e           exp_rd_op;

	read_ctrl_top read_ctrl_top_inst (
		.clock          (clock),
		.rstn           (rstn),
		.job            (job),
		.prefetch_en    (prefetch_en),
		.read_stall     (read_stall),
		.prefetch_stall (prefetch_stall),
		.read_resp      (read_resp),
		.prefetch_resp  (prefetch_resp),
		.read_cmd       (read_cmd),
		.prefetch_cmd   (prefetch_cmd),
		.done           (done),
		.done_elems     (done_elems)
	);

	cmd_responder #(.DELAY_MAX(6), .SEED(SEED)) read_responder (
		.clock (clock),
		.rstn  (rstn),
		.cmd   (read_cmd),
		.resp  (read_resp)
	);

	cmd_responder #(.DELAY_MAX(12), .SEED(SEED)) touch_responder (
		.clock (clock),
		.rstn  (rstn),
		.cmd   (prefetch_cmd),
		.resp  (prefetch_resp)
	);

	initial begin
		forever #50 clock = ~clock;
	end

	////////////////////
	// expected values
	////////////////////

	always_comb begin
		pf_base     = cur_base & ~(ADDR_W'(PAGE_BYTES - 1));
		n_reads     = (cur_size + CACHELINE_ELEMS - 1) / CACHELINE_ELEMS;
		n_pages     = (cur_size + PAGE_ELEMS - 1) / PAGE_ELEMS;
		rd_left     = cur_size - rd_issued * CACHELINE_ELEMS;
		pf_left     = cur_size - pf_issued * PAGE_ELEMS;
		exp_rd_size = (rd_left < CACHELINE_ELEMS) ? rd_left : CACHELINE_ELEMS;
		exp_pf_size = (pf_left < PAGE_ELEMS) ? pf_left : PAGE_ELEMS;
		exp_rd_addr = cur_base + ADDR_W'(rd_issued) * ADDR_W'(CACHELINE_BYTES);
		exp_pf_addr = pf_base + ADDR_W'(pf_issued) * ADDR_W'(PAGE_BYTES);
		rd_page     = int'((read_cmd.chunk.address - pf_base) / ADDR_W'(PAGE_BYTES));
		if (cur_shared)
			exp_rd_op = READ_CL_S;
		else if (rd_issued == n_reads - 1)
			exp_rd_op = READ_PNA;
		else
			exp_rd_op = READ_CL_NA;
	end

	always @(posedge clock) begin
		rstall_q1 <= read_stall;
		rstall_q2 <= rstall_q1;
		pstall_q1 <= prefetch_stall;
		pstall_q2 <= pstall_q1;
		if (!rstn) begin
			rd_issued   <= 0;
			rd_answered <= 0;
			rd_sum      <= 0;
			pf_issued   <= 0;
			pf_answered <= 0;
		end else begin
			if (read_cmd.chunk.valid) begin
				rd_issued <= rd_issued + 1;
				rd_sum    <= rd_sum + int'(read_cmd.chunk.real_size);
			end
			if (read_resp.valid)
				rd_answered <= rd_answered + 1;
			if (prefetch_cmd.chunk.valid)
				pf_issued <= pf_issued + 1;
			if (prefetch_resp.valid)
				pf_answered <= pf_answered + 1;
		end
	end

	////////////////////
	// checks
	////////////////////

	task automatic fail_check(input string msg);
		$display("[FAIL] %0t %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first check error");
	endtask

	assert property (@(posedge clock) rstn || (read_cmd == '0 && prefetch_cmd == '0
		&& !done && done_elems == '0))
		else fail_check("outputs not zero during reset");
	assert property (@(posedge clock) disable iff (!rstn)
		!read_cmd.chunk.valid || read_cmd.chunk.address == exp_rd_addr)
		else fail_check("read address off the cacheline step");
	assert property (@(posedge clock) disable iff (!rstn) !read_cmd.chunk.valid
		|| (rd_issued < n_reads && int'(read_cmd.chunk.real_size) == exp_rd_size))
		else fail_check("read real_size wrong or read beyond the job");
	assert property (@(posedge clock) disable iff (!rstn)
		!read_cmd.chunk.valid || read_cmd.op == exp_rd_op)
		else fail_check("read opcode wrong");
	assert property (@(posedge clock) disable iff (!rstn)
		rd_issued - rd_answered <= MAX_BATCH_READS)
		else fail_check("more reads outstanding than one batch");
	assert property (@(posedge clock) disable iff (!rstn)
		!(read_cmd.chunk.valid && rstall_q2))
		else fail_check("read command issued under stall");
	assert property (@(posedge clock) disable iff (!rstn)
		!(prefetch_cmd.chunk.valid && pstall_q2))
		else fail_check("touch command issued under stall");
	assert property (@(posedge clock) disable iff (!rstn)
		!prefetch_cmd.chunk.valid || cur_pf)
		else fail_check("touch issued with prefetch disabled");
	assert property (@(posedge clock) disable iff (!rstn) !prefetch_cmd.chunk.valid
		|| (pf_issued < n_pages && prefetch_cmd.chunk.address == exp_pf_addr
		&& int'(prefetch_cmd.chunk.real_size) == exp_pf_size && prefetch_cmd.op == TOUCH_I))
		else fail_check("touch address, size or opcode wrong");
	assert property (@(posedge clock) disable iff (!rstn)
		!read_cmd.chunk.valid || !cur_pf || rd_page < pf_answered)
		else fail_check("read issued before its page touch was answered");
	assert property (@(posedge clock) disable iff (!rstn)
		!done || (rd_issued == rd_answered && pf_issued == pf_answered))
		else fail_check("done with commands still unanswered");
	assert property (@(posedge clock) disable iff (!rstn) !done
		|| (rd_issued == n_reads && rd_sum == cur_size && int'(done_elems) == cur_size
		&& pf_issued == (cur_pf ? n_pages : 0)))
		else fail_check("done with wrong read, touch or element totals");
	assert property (@(posedge clock) disable iff (!rstn)
		!(done && (read_cmd.chunk.valid || prefetch_cmd.chunk.valid)))
		else fail_check("command after done");

	////////////////////
	// stimulus
	////////////////////

	// each port stalls about one cycle in four
	always @(negedge clock) begin
		read_stall     = (($random(seed) & 3) == 0);
		prefetch_stall = (($random(seed) & 3) == 0);
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: a job never completed within %0d cycles", limit);
			$display("TEST FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic make_jobs();
		for (int i = 0; i < NUM_JOBS; i++) begin
			// base offsets stay below one cacheline
			job_base[i] = (ADDR_W'($unsigned($random(seed)) & 32'hfffff) << 12)
				| ADDR_W'(($unsigned($random(seed)) % 32) * ELEM_BYTES);
			job_shared[i] = i[0];
			job_pf[i]     = (i != 1) && (i != 2);
		end
		job_size[0] = 100;
		job_size[1] = 100;
		job_size[2] = 32 * (1 + $unsigned($random(seed)) % 8) + 1 + $unsigned($random(seed)) % 31;
		job_size[3] = 1 + $unsigned($random(seed)) % 300;
		job_size[4] = 1500;
		job_size[5] = 64;
		limit = 0;
		for (int i = 0; i < NUM_JOBS; i++) begin
			limit += 200 * ((job_size[i] + CACHELINE_ELEMS - 1) / CACHELINE_ELEMS);
			if (job_pf[i])
				limit += 200 * ((job_size[i] + PAGE_ELEMS - 1) / PAGE_ELEMS);
		end
	endtask

	task automatic run_job(input int idx);
		rstn       = 1'b0;
		cur_base   = job_base[idx];
		cur_size   = job_size[idx];
		cur_shared = job_shared[idx];
		cur_pf     = job_pf[idx];
		repeat (16) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		prefetch_en    = cur_pf;
		job.valid      = 1'b1;
		job.base_addr  = cur_base;
		job.size       = SIZE_W'(cur_size);
		job.shared     = cur_shared;
		@(negedge clock);
		job = '0;
		while (!done)
			@(negedge clock);
		// quiet window after done
		repeat (8) @(negedge clock);
	endtask

	initial begin
		seed           = SEED;
		cycles         = 0;
		rstn           = 1'b1;
		job            = '0;
		prefetch_en    = 1'b0;
		read_stall     = 1'b0;
		prefetch_stall = 1'b0;
		cur_base       = '0;
		cur_size       = 0;
		cur_shared     = 1'b0;
		cur_pf         = 1'b0;
		make_jobs();
		#1;
		for (int i = 0; i < NUM_JOBS; i++)
			run_job(i);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* read_ctrl.f */
src/read_ctrl_pkg.sv
src/chunk_issuer.sv
src/read_sequencer.sv
src/read_ctrl_top.sv
sim/cmd_responder.sv
sim/tb_read_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_read_ctrl -f read_ctrl.f -o tb_read_ctrl > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_read_ctrl > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
